// ==== files.f ====
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_ctrl.sv
hw/refill_buffer.sv
hw/branch_predecode.sv
hw/inst_queue.sv
hw/fetch_top.sv
dv/bmem_model.sv
dv/fetch_tb.sv

// ==== Makefile ====
TOP = fetch_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f files.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir

// ==== dv/fetch_tb.sv ====
`include "fetch_consts.svh"

module fetch_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] RESET_PC   = `FETCH_RESET_PC;
    localparam logic [31:0] LOOP_PC    = `FETCH_RESET_PC + 32'h140;
    localparam logic [31:0] BRANCH_PC  = `FETCH_RESET_PC + 32'h200;
    localparam int          WAIT_LIMIT = 4000;
    localparam int          CNT_POPS   = 0;
    localparam int          CNT_FALL   = 1;
    localparam int          CNT_TAKEN  = 2;

    logic                    clk;
    logic                    rst;
    logic [31:0]             bmem_addr_o;
    logic                    bmem_read_o;
    logic                    bmem_ready_i;
    logic [`BEAT_BITS-1:0]   bmem_rdata_i;
    logic                    bmem_rvalid_i;
    fetch_pkg::resolve_t     resolve_i;
    fetch_pkg::redirect_t    redirect_i;
    logic                    fetch_valid_o;
    fetch_pkg::fetch_entry_t fetch_entry_o;
    logic                    fetch_deq_i;
    logic [31:0]             model_word;

    // reference state advanced at each rising edge
    logic        pop;
    logic [31:0] exp_pc;
    logic [1:0]  exp_ctr;
    int          beats_left;
    int          pop_cnt = 0;
    int          fall_cnt = 0;
    int          taken_cnt = 0;
    int          errors = 0;
    int          timeouts = 0;
    int          seed;
    int          pause_left;

    fetch_top dut0 (.*);

    bmem_model mem0 (
        .clk         (clk),
        .rst         (rst),
        .read_i      (bmem_read_o),
        .addr_i      (bmem_addr_o),
        .ready_o     (bmem_ready_i),
        .rdata_o     (bmem_rdata_i),
        .rvalid_o    (bmem_rvalid_i),
        .peek_addr_i (fetch_entry_o.pc),
        .peek_word_o (model_word)
    );

    // RISC-V immediates straight from the bit positions
    function automatic logic [31:0] jal_offset(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic logic [31:0] branch_offset(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] follow_pc(input fetch_pkg::fetch_entry_t e);
        if (!e.pred_taken) begin
            return e.pc + 32'd4;
        end else if (e.inst[6:0] == `OP_JAL) begin
            return e.pc + jal_offset(e.inst);
        end
        return e.pc + branch_offset(e.inst);
    endfunction

    function automatic int count_of(input int sel);
        case (sel)
            CNT_POPS: return pop_cnt;
            CNT_FALL: return fall_cnt;
            default:  return taken_cnt;
        endcase
    endfunction

    task automatic note_mismatch(input string msg);
        errors++;
        $display("FAILED at %0d ns: %s", $time, msg);
    endtask

    task automatic wait_until(input int sel, input int target, input string what);
        int cycles;
        cycles = 0;
        while (count_of(sel) < target && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (count_of(sel) < target) begin
            timeouts++;
            $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
        end
    endtask

    // redirect pulse optionally carrying a resolved outcome for the branch
    task automatic restart_fetch(input logic [31:0] pc, input logic train, input logic taken);
        @(negedge clk);
        redirect_i.valid = 1'b1;
        redirect_i.pc    = pc;
        resolve_i.valid  = train;
        resolve_i.pc     = BRANCH_PC;
        resolve_i.taken  = taken;
        @(negedge clk);
        redirect_i = '0;
        resolve_i  = '0;
    endtask

    assign pop = fetch_valid_o && fetch_deq_i;

    always @(posedge clk) begin
        if (rst) begin
            exp_pc     <= RESET_PC;
            exp_ctr    <= 2'b01;
            beats_left <= 0;
        end else begin
            if (pop) begin
                exp_pc  <= follow_pc(fetch_entry_o);
                pop_cnt <= pop_cnt + 1;
                if (fetch_entry_o.pc == BRANCH_PC && fetch_entry_o.pred_taken) begin
                    taken_cnt <= taken_cnt + 1;
                end else if (fetch_entry_o.pc == BRANCH_PC) begin
                    fall_cnt <= fall_cnt + 1;
                end
            end
            if (redirect_i.valid) begin
                exp_pc <= redirect_i.pc;
            end
            // saturating counter of the branch's table entry
            if (resolve_i.valid && resolve_i.taken && exp_ctr != 2'b11) begin
                exp_ctr <= exp_ctr + 2'b01;
            end else if (resolve_i.valid && !resolve_i.taken && exp_ctr != 2'b00) begin
                exp_ctr <= exp_ctr - 2'b01;
            end
            if (bmem_read_o) begin
                beats_left <= `BEATS_PER_LINE;
            end else if (bmem_rvalid_i && beats_left > 0) begin
                beats_left <= beats_left - 1;
            end
        end
    end

    a_inst_word: assert property (@(posedge clk) disable iff (rst)
        pop |-> fetch_entry_o.inst == model_word)
        else note_mismatch("popped word differs from memory");
    a_pc_order: assert property (@(posedge clk) disable iff (rst)
        pop |-> fetch_entry_o.pc == exp_pc)
        else note_mismatch("popped pc does not follow the previous entry or redirect");
    a_jal_taken: assert property (@(posedge clk) disable iff (rst)
        pop && fetch_entry_o.inst[6:0] == `OP_JAL |-> fetch_entry_o.pred_taken)
        else note_mismatch("jal not steered to its target");
    a_branch_pred: assert property (@(posedge clk) disable iff (rst)
        pop && fetch_entry_o.inst[6:0] == `OP_BRANCH |-> fetch_entry_o.pred_taken == exp_ctr[1])
        else note_mismatch("branch prediction disagrees with its counter");
    a_plain_seq: assert property (@(posedge clk) disable iff (rst)
        pop && fetch_entry_o.inst[6:0] != `OP_JAL && fetch_entry_o.inst[6:0] != `OP_BRANCH
        |-> !fetch_entry_o.pred_taken)
        else note_mismatch("non-branch word marked taken");
    a_flush_empty: assert property (@(posedge clk) disable iff (rst)
        redirect_i.valid |=> !fetch_valid_o)
        else note_mismatch("queue not empty after redirect");
    a_read_aligned: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |-> bmem_addr_o[`LINE_OFFSET_BITS-1:0] == '0)
        else note_mismatch("read address not line aligned");
    a_read_single: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |-> beats_left == 0)
        else note_mismatch("read issued before the previous line arrived");

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // random pops with long stalls so the queue fills up
    initial begin
        seed        = 91;
        pause_left  = 0;
        fetch_deq_i = 1'b0;
        forever begin
            @(negedge clk);
            if (pause_left > 0) begin
                pause_left  = pause_left - 1;
                fetch_deq_i = 1'b0;
            end else if ({$random(seed)} % 24 == 0) begin
                pause_left  = 24 + {$random(seed)} % 24;
                fetch_deq_i = 1'b0;
            end else begin
                fetch_deq_i = ({$random(seed)} % 4) != 0;
            end
        end
    end

    initial begin
        int fall_before;
        rst        = 1'b1;
        resolve_i  = '0;
        redirect_i = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        // through the jal and past the untrained branch
        wait_until(CNT_FALL, 1, "the first fetch of the branch");
        wait_until(CNT_POPS, pop_cnt + 30, "fetch past the branch");
        // second redirect lands while the first refill is still out
        restart_fetch(RESET_PC + 32'h2000, 1'b0, 1'b0);
        restart_fetch(RESET_PC + 32'h3000, 1'b0, 1'b0);
        wait_until(CNT_POPS, pop_cnt + 20, "fetch after back-to-back redirects");
        restart_fetch(LOOP_PC, 1'b1, 1'b1);
        restart_fetch(LOOP_PC, 1'b1, 1'b1);
        wait_until(CNT_TAKEN, taken_cnt + 2, "the branch predicted taken");
        // two not-taken outcomes bring the counter back below taken
        fall_before = fall_cnt;
        restart_fetch(LOOP_PC, 1'b1, 1'b0);
        restart_fetch(LOOP_PC, 1'b1, 1'b0);
        wait_until(CNT_FALL, fall_before + 1, "the branch falling through again");
        wait_until(CNT_POPS, pop_cnt + 10, "fetch after the branch");
        repeat (4) @(negedge clk);
        $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/bmem_model.sv ====
`include "fetch_consts.svh"

module bmem_model (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  read_i,
    input  logic [31:0]           addr_i,
    output logic                  ready_o,
    output logic [`BEAT_BITS-1:0] rdata_o,
    output logic                  rvalid_o,
    input  logic [31:0]           peek_addr_i,
    output logic [31:0]           peek_word_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] JAL_PC    = `FETCH_RESET_PC + 32'h40;
    localparam logic [31:0] BRANCH_PC = `FETCH_RESET_PC + 32'h200;

    int          seed;
    int          delay;
    int          gap;
    logic [31:0] base;

    // addi filler that mixes in every address bit, plus the two-instruction program
    function automatic logic [31:0] word_at(input logic [31:0] a);
        fetch_pkg::rv_inst_u w;
        w = {a[31:7] ^ {a[6:2], 20'h0}, 7'b0010011};
        if (a == JAL_PC) begin
            // jal x0, +0x100
            w.j         = '0;
            w.j.imm10_1 = 10'h080;
            w.j.opcode  = `OP_JAL;
        end else if (a == BRANCH_PC) begin
            // beq x0, x0, -0x20
            w.b         = '0;
            w.b.imm12   = 1'b1;
            w.b.imm11   = 1'b1;
            w.b.imm10_5 = 6'h3f;
            w.b.opcode  = `OP_BRANCH;
        end
        return w;
    endfunction

    assign ready_o     = 1'b1;
    assign peek_word_o = word_at(peek_addr_i);

    initial begin
        seed     = 91;
        rvalid_o = 1'b0;
        rdata_o  = '0;
        forever begin
            @(posedge clk);
            if (read_i && !rst) begin
                base  = addr_i;
                delay = {$random(seed)} % 6;
                @(negedge clk);
                repeat (delay) @(negedge clk);
                // lowest beat first, random gaps between beats
                for (int b = 0; b < `BEATS_PER_LINE; b++) begin
                    rvalid_o = 1'b1;
                    rdata_o  = {word_at(base + 32'(8 * b + 4)), word_at(base + 32'(8 * b))};
                    @(negedge clk);
                    rvalid_o = 1'b0;
                    if (b < `BEATS_PER_LINE - 1) begin
                        gap = {$random(seed)} % 3;
                        repeat (gap) @(negedge clk);
                    end
                end
            end
        end
    end

endmodule

// ==== hw/fetch_top.sv ====
`include "fetch_consts.svh"

module fetch_top (
    input  logic                    clk,
    input  logic                    rst,
    output logic [31:0]             bmem_addr_o,
    output logic                    bmem_read_o,
    input  logic                    bmem_ready_i,
    input  logic [`BEAT_BITS-1:0]   bmem_rdata_i,
    input  logic                    bmem_rvalid_i,
    input  fetch_pkg::resolve_t     resolve_i,
    input  fetch_pkg::redirect_t    redirect_i,
    output logic                    fetch_valid_o,
    output fetch_pkg::fetch_entry_t fetch_entry_o,
    input  logic                    fetch_deq_i
);

    logic [31:0]             pc;
    logic                    line_hit;
    logic [31:0]             hit_word;
    logic                    line_done;
    logic [31:0]             next_pc;
    logic                    pred_taken;
    logic                    enq;
    fetch_pkg::fetch_entry_t enq_entry;
    logic                    iq_full;

    fetch_ctrl ctrl0 (
        .clk          (clk),
        .rst          (rst),
        .line_hit_i   (line_hit),
        .hit_word_i   (hit_word),
        .line_done_i  (line_done),
        .next_pc_i    (next_pc),
        .pred_taken_i (pred_taken),
        .iq_full_i    (iq_full),
        .bmem_ready_i (bmem_ready_i),
        .redirect_i   (redirect_i),
        .pc_o         (pc),
        .enq_o        (enq),
        .enq_entry_o  (enq_entry),
        .bmem_read_o  (bmem_read_o),
        .bmem_addr_o  (bmem_addr_o)
    );

    refill_buffer rbuf0 (
        .clk           (clk),
        .rst           (rst),
        .pc_i          (pc),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .bmem_addr_i   (bmem_addr_o),
        .bmem_read_i   (bmem_read_o),
        .line_hit_o    (line_hit),
        .hit_word_o    (hit_word),
        .line_done_o   (line_done)
    );

    branch_predecode pdec0 (
        .clk          (clk),
        .rst          (rst),
        .pc_i         (pc),
        .inst_i       (hit_word),
        .resolve_i    (resolve_i),
        .next_pc_o    (next_pc),
        .pred_taken_o (pred_taken)
    );

    // redirect empties the queue
    inst_queue iq0 (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (redirect_i.valid),
        .enq_i       (enq),
        .enq_entry_i (enq_entry),
        .deq_i       (fetch_deq_i),
        .full_o      (iq_full),
        .valid_o     (fetch_valid_o),
        .entry_o     (fetch_entry_o)
    );

endmodule

// ==== hw/inst_queue.sv ====
`include "fetch_consts.svh"

module inst_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush_i,
    input  logic                    enq_i,
    input  fetch_pkg::fetch_entry_t enq_entry_i,
    input  logic                    deq_i,
    output logic                    full_o,
    output logic                    valid_o,
    output fetch_pkg::fetch_entry_t entry_o
);

    localparam int PTR_BITS = $clog2(`IQ_DEPTH);

    fetch_pkg::fetch_entry_t mem [`IQ_DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                do_enq;
    logic                do_deq;

    assign full_o  = (count == (PTR_BITS + 1)'(`IQ_DEPTH));
    assign valid_o = (count != '0);
    assign entry_o = mem[rd_ptr];

    // pops on an empty queue are dropped
    assign do_enq = enq_i && !full_o;
    assign do_deq = deq_i && valid_o;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_enq && !do_deq) begin
                count <= count + 1'b1;
            end else if (do_deq && !do_enq) begin
                count <= count - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr] <= enq_entry_i;
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        count <= (PTR_BITS + 1)'(`IQ_DEPTH)
    ) else $error("queue count overflow");

endmodule

// ==== hw/branch_predecode.sv ====
`include "fetch_consts.svh"

module branch_predecode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [31:0]          pc_i,
    input  logic [31:0]          inst_i,
    input  fetch_pkg::resolve_t  resolve_i,
    output logic [31:0]          next_pc_o,
    output logic                 pred_taken_o
);

    localparam int BHT_ENTRIES = 1 << `BHT_INDEX_BITS;

    fetch_pkg::rv_inst_u inst_u;

    logic [31:0] b_imm;
    logic [31:0] j_imm;
    logic        is_jal;
    logic        is_branch;

    // bimodal table of 2-bit saturating counters
    logic [1:0]                 bht [BHT_ENTRIES];
    logic [`BHT_INDEX_BITS-1:0] rd_idx;
    logic [`BHT_INDEX_BITS-1:0] wr_idx;
    logic [1:0]                 rd_ctr;
    logic [1:0]                 wr_ctr;

    assign inst_u = inst_i;

    // both formats keep the opcode in the low seven bits
    assign is_jal    = (inst_u.j.opcode == `OP_JAL);
    assign is_branch = (inst_u.b.opcode == `OP_BRANCH);

    // B immediate, 13 bits sign extended
    assign b_imm = {{19{inst_u.b.imm12}}, inst_u.b.imm12, inst_u.b.imm11,
                    inst_u.b.imm10_5, inst_u.b.imm4_1, 1'b0};

    // J immediate, 21 bits sign extended
    assign j_imm = {{11{inst_u.j.imm20}}, inst_u.j.imm20, inst_u.j.imm19_12,
                    inst_u.j.imm11, inst_u.j.imm10_1, 1'b0};

    // index skips the word offset
    assign rd_idx = pc_i[`BHT_INDEX_BITS+1:2];
    assign wr_idx = resolve_i.pc[`BHT_INDEX_BITS+1:2];
    assign rd_ctr = bht[rd_idx];
    assign wr_ctr = bht[wr_idx];

    always_comb begin
        next_pc_o    = pc_i + 32'd4;
        pred_taken_o = 1'b0;
        if (is_jal) begin
            next_pc_o    = pc_i + j_imm;
            pred_taken_o = 1'b1;
        end else if (is_branch && rd_ctr[1]) begin
            // weakly or strongly taken
            next_pc_o    = pc_i + b_imm;
            pred_taken_o = 1'b1;
        end
    end

    // training from resolved branches, visible the next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                bht[i] <= 2'b01;
            end
        end else if (resolve_i.valid) begin
            if (resolve_i.taken && (wr_ctr != 2'b11)) begin
                bht[wr_idx] <= wr_ctr + 2'b01;
            end else if (!resolve_i.taken && (wr_ctr != 2'b00)) begin
                bht[wr_idx] <= wr_ctr - 2'b01;
            end
        end
    end

endmodule

// ==== hw/refill_buffer.sv ====
`include "fetch_consts.svh"

module refill_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           pc_i,
    input  logic [`BEAT_BITS-1:0] bmem_rdata_i,
    input  logic                  bmem_rvalid_i,
    input  logic [31:0]           bmem_addr_i,
    input  logic                  bmem_read_i,
    output logic                  line_hit_o,
    output logic [31:0]           hit_word_o,
    output logic                  line_done_o
);

    localparam int TAG_BITS      = 32 - `LINE_OFFSET_BITS;
    localparam int BEAT_CNT_BITS = $clog2(`BEATS_PER_LINE);
    localparam int WORD_SEL_BITS = $clog2(`WORDS_PER_LINE);

    // refill in progress
    logic                     pending;
    logic [BEAT_CNT_BITS-1:0] beat_cnt;
    logic [TAG_BITS-1:0]      req_tag;
    logic [`LINE_BITS-1:0]    line_shift;
    logic [`LINE_BITS-1:0]    line_next;

    // line currently served to fetch
    logic                                 held_valid;
    logic [TAG_BITS-1:0]                  held_tag;
    logic [`WORDS_PER_LINE-1:0][31:0]     held_line;
    logic [WORD_SEL_BITS-1:0]             word_sel;

    // beats come in lowest first, so shift in from the top
    assign line_next   = {bmem_rdata_i, line_shift[`LINE_BITS-1:`BEAT_BITS]};
    assign line_done_o = bmem_rvalid_i &&
                         (beat_cnt == BEAT_CNT_BITS'(`BEATS_PER_LINE - 1));

    assign word_sel   = pc_i[`LINE_OFFSET_BITS-1:2];
    assign line_hit_o = held_valid && (held_tag == pc_i[31:`LINE_OFFSET_BITS]);
    assign hit_word_o = held_line[word_sel];

    always_ff @(posedge clk) begin
        if (rst) begin
            pending    <= 1'b0;
            beat_cnt   <= '0;
            held_valid <= 1'b0;
        end else begin
            if (bmem_read_i) begin
                pending <= 1'b1;
            end else if (line_done_o) begin
                pending <= 1'b0;
            end
            if (line_done_o) begin
                beat_cnt   <= '0;
                held_valid <= 1'b1;
            end else if (bmem_rvalid_i) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // line data and tags
    always_ff @(posedge clk) begin
        if (bmem_read_i) begin
            req_tag <= bmem_addr_i[31:`LINE_OFFSET_BITS];
        end
        if (bmem_rvalid_i) begin
            line_shift <= line_next;
        end
        if (line_done_o) begin
            held_line <= line_next;
            held_tag  <= req_tag;
        end
    end

    // every beat belongs to an open request, at most four per read
    a_beats_per_request: assert property (
        @(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> pending
    ) else $error("burst beat outside a refill");

endmodule

// ==== hw/fetch_ctrl.sv ====
`include "fetch_consts.svh"

module fetch_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    line_hit_i,
    input  logic [31:0]             hit_word_i,
    input  logic                    line_done_i,
    input  logic [31:0]             next_pc_i,
    input  logic                    pred_taken_i,
    input  logic                    iq_full_i,
    input  logic                    bmem_ready_i,
    input  fetch_pkg::redirect_t    redirect_i,
    output logic [31:0]             pc_o,
    output logic                    enq_o,
    output fetch_pkg::fetch_entry_t enq_entry_o,
    output logic                    bmem_read_o,
    output logic [31:0]             bmem_addr_o
);

    // current fetch address
    logic [31:0] pc_q;

    // set from the read pulse until the line is in the buffer
    logic waiting;

    // cycle-level decisions
    logic hit_enq;
    logic miss_req;

    assign pc_o = pc_q;

    // a redirect takes the cycle while the queue is flushed
    assign hit_enq = line_hit_i && !iq_full_i && !redirect_i.valid;

    // miss only starts a refill when nothing is outstanding and reset is over
    assign miss_req = !rst && !line_hit_i && !waiting && bmem_ready_i && !redirect_i.valid;

    always_comb begin
        enq_entry_o.pc         = pc_q;
        enq_entry_o.inst       = hit_word_i;
        enq_entry_o.pred_taken = pred_taken_i;
    end

    assign enq_o = hit_enq;

    // line aligned request
    assign bmem_read_o = miss_req;
    assign bmem_addr_o = {pc_q[31:`LINE_OFFSET_BITS], {`LINE_OFFSET_BITS{1'b0}}};

    // pc register
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= `FETCH_RESET_PC;
        end else if (redirect_i.valid) begin
            pc_q <= redirect_i.pc;
        end else if (hit_enq) begin
            pc_q <= next_pc_i;
        end
    end

    // fetch / wait-refill state
    // a hit on the held line may still enqueue while a refill is pending
    always_ff @(posedge clk) begin
        if (rst) begin
            waiting <= 1'b0;
        end else if (line_done_i) begin
            waiting <= 1'b0;
        end else if (miss_req) begin
            waiting <= 1'b1;
        end
    end

    // refill completions only arrive for a read this block is waiting on
    a_done_while_waiting: assert property (
        @(posedge clk) disable iff (rst)
        line_done_i |-> waiting
    ) else $error("line_done without an outstanding read");

    // a second read must not go out before the first line lands
    a_no_read_while_waiting: assert property (
        @(posedge clk) disable iff (rst)
        waiting |-> !bmem_read_o
    ) else $error("read pulse while a refill is outstanding");

    // enqueue into a full queue would drop the entry
    a_no_enq_when_full: assert property (
        @(posedge clk) disable iff (rst)
        iq_full_i |-> !enq_o
    ) else $error("enqueue while queue full");

endmodule

// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

    // one fetched instruction as it sits in the queue
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        pred_taken;
    } fetch_entry_t;

    // B-type field layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // J-type field layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // same word, read as either format
    typedef union packed {
        b_fmt_t b;
        j_fmt_t j;
    } rv_inst_u;

    // branch outcome from the back end
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
    } resolve_t;

    // flush and restart request
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

endpackage

// ==== hw/fetch_consts.svh ====
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// pc after reset
`define FETCH_RESET_PC    32'haaaaa000

// cache line and burst geometry
`define LINE_BITS         256
`define BEAT_BITS         64
`define BEATS_PER_LINE    4
`define WORDS_PER_LINE    8
`define LINE_OFFSET_BITS  5

// queue depth and counter table index width (64 entries)
`define IQ_DEPTH          16
`define BHT_INDEX_BITS    6

// opcodes recognised by predecode
`define OP_JAL            7'b1101111
`define OP_BRANCH         7'b1100011

`endif
